// File: Bender.yml
package:
  name: adc_rx

sources:
  - files:
      - source/adc_rx_pkg.sv
      - source/lane_if.sv
      - source/word_if.sv
      - source/lane_sampler.sv
      - source/word_assembler.sv
      - source/sample_formatter.sv
      - source/adc_rx_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/adc_rx_tb.sv

// File: adc_rx.f
+incdir+sim
source/adc_rx_pkg.sv
source/lane_if.sv
source/word_if.sv
source/lane_sampler.sv
source/word_assembler.sv
source/sample_formatter.sv
source/adc_rx_top.sv
sim/adc_rx_tb.sv

// File: sim/adc_rx_tb_tasks.svh
/*
 * Stimulus and checking helpers included into the receive path testbench.
 * Expects the DUT input signals and the counters to be declared before it
 */

`ifndef ADC_RX_TB_TASKS_SVH
`define ADC_RX_TB_TASKS_SVH

// ********************
// Random bits
// ********************

// Fibonacci LFSR on x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
  logic fb;
  fb = state[31] ^ state[21] ^ state[1] ^ state[0];
  return {state[30:0], fb};
endfunction

// Steps the LFSR once per bit and shifts each new bit in at the bottom
task automatic draw_bits(input int count, output logic [31:0] bits);
  int k;
  bits = '0;
  for (k = 0; k < count; k++) begin
    lfsr_state = lfsr_next(lfsr_state);
    bits       = {bits[30:0], lfsr_state[0]};
  end
endtask

// ********************
// Checking
// ********************

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
  if (expected !== actual) begin
    $display("Error at %0d ns: %s expected %0h, actual %0h", $time, name, expected, actual);
    error_cnt++;
  end
endtask

// ********************
// Converter lane model
// ********************

// Sends up to beats beats of a word MSB first, strobing frame_start on the first
// In two-lane mode da carries the higher bit of each pair and db the next one
task automatic drive_frame(input adc_rx_pkg::sample_t word, input logic lane2,
                           input logic ob, input int beats);
  int b;
  int limit;
  limit = lane2 ? adc_rx_pkg::BEATS_2L : adc_rx_pkg::BEATS_1L;
  for (b = 0; b < beats && b < limit; b++) begin
    @(posedge sync_n_d);
    frame_start <= (b == 0);
    two_lane    <= lane2;
    offset_bin  <= ob;
    if (lane2) begin
      da <= word[adc_rx_pkg::SAMPLE_W-1-2*b];
      db <= word[adc_rx_pkg::SAMPLE_W-2-2*b];
    end else begin
      da <= word[adc_rx_pkg::SAMPLE_W-1-b];
      db <= 1'b0;
    end
  end
endtask

`endif

// File: sim/adc_rx_tb.sv
/*
 * Testbench for the converter receive path. Drives frames in both lane modes
 * and both word formats, then checks samples, frame errors and latency
 */

`timescale 1ns/10ps

module adc_rx_tb;

  // ********************
  // Run length
  // ********************

  localparam int RESET_CYCLES = 2;
  localparam int NUM_TESTS    = 6;
  // Beats of the idle, one-lane, two-lane, offset binary, cut-short and
  // latency tests in that order
  localparam int TOTAL_BEATS  = 30 + 40 * 20 + 40 * 10 + 20 * 20 + 20 * 10 + (7 + 20) + 20;
  // Pipeline drain and settle time at the end of each test
  localparam int TEST_TAIL    = 12;
  localparam int RUN_LIMIT    = RESET_CYCLES + TOTAL_BEATS + NUM_TESTS * TEST_TAIL + 50;

  logic                    sync_n_d;
  logic                    rst;
  logic                    da;
  logic                    db;
  logic                    frame_start;
  logic                    two_lane;
  logic                    offset_bin;
  adc_rx_pkg::out_sample_t sample;
  logic                    sample_valid;
  logic                    frame_error;

  adc_rx_pkg::out_sample_t exp_q[$];
  logic [31:0]             lfsr_state;
  int                      error_cnt;
  int                      test_cnt;
  int                      sample_cnt;
  int                      err_pulses;
  int                      expected_errs;
  int                      cycle_cnt;

  `include "adc_rx_tb_tasks.svh"

  adc_rx_top dut0 (
    .sync_n_d     (sync_n_d),
    .rst          (rst),
    .da           (da),
    .db           (db),
    .frame_start  (frame_start),
    .two_lane     (two_lane),
    .offset_bin   (offset_bin),
    .sample       (sample),
    .sample_valid (sample_valid),
    .frame_error  (frame_error)
  );

  always #10 sync_n_d = ~sync_n_d;

  // Builds the expected output sample for one raw word
  // Offset binary inverts the MSB and the signed assignment extends the sign
  function automatic adc_rx_pkg::out_sample_t expected_sample(
    input adc_rx_pkg::sample_t raw,
    input logic                ob
  );
    logic signed [adc_rx_pkg::SAMPLE_W-1:0] value;
    adc_rx_pkg::out_sample_t                result;
    value = raw;
    if (ob) begin
      value[adc_rx_pkg::SAMPLE_W-1] = ~value[adc_rx_pkg::SAMPLE_W-1];
    end
    result = value;
    return result;
  endfunction

  // Queues the expected sample and sends the whole frame
  task automatic send_word(input adc_rx_pkg::sample_t word, input logic lane2, input logic ob);
    exp_q.push_back(expected_sample(word, ob));
    drive_frame(word, lane2, ob, adc_rx_pkg::SAMPLE_W);
  endtask

  // Waits for every queued sample, lets stray strobes show up, then reports
  task automatic finish_test(input string name);
    while (exp_q.size() != 0) begin
      @(negedge sync_n_d);
    end
    repeat (5) @(negedge sync_n_d);
    check_value("frame_error count", expected_errs, err_pulses);
    test_cnt++;
    $display("Test %0d (%s) finished, %0d errors so far", test_cnt, name, error_cnt);
  endtask

  // ********************
  // Output checking
  // ********************

  // Outputs are sampled at the falling edge, half a cycle after they move
  always @(negedge sync_n_d) begin
    if (!rst) begin
      if (sample_valid) begin
        if (exp_q.size() == 0) begin
          $display("Unexpected sample_valid at %0d ns with no sample pending", $time);
          error_cnt++;
        end else begin
          check_value("sample", exp_q.pop_front(), sample);
          sample_cnt++;
        end
      end
      if (frame_error) begin
        err_pulses++;
      end
    end
  end

  // Ends a run that stops making progress
  always @(posedge sync_n_d) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= RUN_LIMIT) begin
      $display("Run timed out after %0d cycles", cycle_cnt);
      $display("TB FAILED");
      $finish;
    end
  end

  // ********************
  // Test sequence
  // ********************

  initial begin
    logic [31:0] bits;
    int          i;
    int          n;
    logic        seen;
    sync_n_d      = 1'b0;
    rst           = 1'b1;
    da            = 1'b0;
    db            = 1'b0;
    frame_start   = 1'b0;
    two_lane      = 1'b0;
    offset_bin    = 1'b0;
    lfsr_state    = 32'h1620_774a;
    error_cnt     = 0;
    test_cnt      = 0;
    sample_cnt    = 0;
    err_pulses    = 0;
    expected_errs = 0;
    cycle_cnt     = 0;
    repeat (RESET_CYCLES) @(posedge sync_n_d);
    rst <= 1'b0;

    // Outputs must come out of reset cleared
    @(negedge sync_n_d);
    check_value("sample_valid", 0, sample_valid);
    check_value("frame_error", 0, frame_error);
    check_value("sample", 0, sample);

    // Lane toggling without a strobe has to leave the assembler idle
    for (i = 0; i < 30; i++) begin
      draw_bits(2, bits);
      @(posedge sync_n_d);
      da <= bits[1];
      db <= bits[0];
    end
    finish_test("idle lanes");

    for (i = 0; i < 40; i++) begin
      draw_bits(adc_rx_pkg::SAMPLE_W, bits);
      send_word(bits[adc_rx_pkg::SAMPLE_W-1:0], 1'b0, 1'b0);
    end
    finish_test("one-lane two's complement");

    // Most negative and most positive words go first
    send_word(20'h80000, 1'b1, 1'b0);
    send_word(20'h7FFFF, 1'b1, 1'b0);
    for (i = 0; i < 38; i++) begin
      draw_bits(adc_rx_pkg::SAMPLE_W, bits);
      send_word(bits[adc_rx_pkg::SAMPLE_W-1:0], 1'b1, 1'b0);
    end
    finish_test("two-lane two's complement");

    for (i = 0; i < 40; i++) begin
      draw_bits(adc_rx_pkg::SAMPLE_W, bits);
      send_word(bits[adc_rx_pkg::SAMPLE_W-1:0], (i >= 20), 1'b1);
    end
    finish_test("offset binary, both modes");

    // A frame cut after seven beats is followed at once by a full frame
    draw_bits(adc_rx_pkg::SAMPLE_W, bits);
    drive_frame(bits[adc_rx_pkg::SAMPLE_W-1:0], 1'b0, 1'b0, 7);
    expected_errs++;
    draw_bits(adc_rx_pkg::SAMPLE_W, bits);
    send_word(bits[adc_rx_pkg::SAMPLE_W-1:0], 1'b0, 1'b0);
    finish_test("cut-short frame");

    // The first falling edge comes after the last drive edge and the second
    // one after the edge that captures the last beat
    draw_bits(adc_rx_pkg::SAMPLE_W, bits);
    send_word(bits[adc_rx_pkg::SAMPLE_W-1:0], 1'b0, 1'b0);
    n    = 0;
    seen = 1'b0;
    while (!seen && n < 10) begin
      @(negedge sync_n_d);
      n++;
      seen = sample_valid;
    end
    if (!seen) begin
      $display("No sample_valid after the isolated frame at %0d ns", $time);
      error_cnt++;
    end else begin
      check_value("sample_valid latency", 3, n - 2);
    end
    finish_test("fixed latency");

    $display("Tests: %0d, samples checked: %0d, frame errors: %0d, errors: %0d",
             test_cnt, sample_cnt, err_pulses, error_cnt);
    if (error_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: source/adc_rx_pkg.sv
/*
 * Widths, beat counts and word types shared by the converter receive path
 * and its testbench. Files refer to these as adc_rx_pkg::name
 */

package adc_rx_pkg;

  // ********************
  // Word widths
  // ********************

  // The converter delivers 20-bit words, MSB first
  localparam int SAMPLE_W = 20;

  // Samples leave the receive path sign-extended to 24 bits
  localparam int OUT_W = 24;

  // ********************
  // Beat counting
  // ********************

  // The beat counter is wide enough to reach the one-lane beat count
  localparam int BEAT_CNT_W = 5;

  // One bit per beat on da alone
  localparam logic [BEAT_CNT_W-1:0] BEATS_1L = 5'd20;

  // Two bits per beat, da carries the higher bit and db the next one down
  localparam logic [BEAT_CNT_W-1:0] BEATS_2L = 5'd10;

  // ********************
  // Word types
  // ********************

  // A raw converter word as it comes off the lanes
  typedef logic [SAMPLE_W-1:0] sample_t;

  // A formatted two's complement output sample
  typedef logic signed [OUT_W-1:0] out_sample_t;

endpackage

// File: source/adc_rx_top.sv
/*
 * Receive path top level for the 20-bit SAR converter serial interface.
 * Chains sampler, assembler and formatter, all clocked by sync_n_d
 */

`timescale 1ns/10ps

module adc_rx_top (
  input  logic                    sync_n_d,
  input  logic                    rst,
  input  logic                    da,
  input  logic                    db,
  input  logic                    frame_start,
  input  logic                    two_lane,
  input  logic                    offset_bin,
  output adc_rx_pkg::out_sample_t sample,
  output logic                    sample_valid,
  output logic                    frame_error
);

  // ********************
  // Stage links
  // ********************

  // Registered beats between the sampler and the assembler
  lane_if lanes ();

  // Finished words between the assembler and the formatter
  word_if words ();

  // ********************
  // Pipeline stages
  // ********************

  // Pads to aligned beats, one cycle
  lane_sampler sampler (
    .sync_n_d    (sync_n_d),
    .rst         (rst),
    .da          (da),
    .db          (db),
    .frame_start (frame_start),
    .two_lane    (two_lane),
    .lanes       (lanes.src)
  );

  // Beats to words, one cycle after the last beat is taken
  word_assembler assembler (
    .sync_n_d   (sync_n_d),
    .rst        (rst),
    .offset_bin (offset_bin),
    .lanes      (lanes.dst),
    .words      (words.src)
  );

  // Words to formatted samples, one cycle
  sample_formatter formatter (
    .sync_n_d     (sync_n_d),
    .rst          (rst),
    .words        (words.dst),
    .sample       (sample),
    .sample_valid (sample_valid),
    .frame_error  (frame_error)
  );

endmodule

// File: source/lane_if.sv
/*
 * Registered lane beats passed from the sampler to the word assembler.
 * The sampler drives the src side and the assembler reads the dst side
 */

`timescale 1ns/10ps

interface lane_if;

  // High on the beat that holds the MSB of a word
  logic first;
  // Lane mode that was registered alongside the beat
  logic two_lane;
  // Lane bits, da is the higher bit of the pair in two-lane mode
  logic da;
  logic db;
  // Beats are present on every cycle once reset has been released
  logic valid;

  modport src (
    output first,
    output two_lane,
    output da,
    output db,
    output valid
  );

  modport dst (
    input first,
    input two_lane,
    input da,
    input db,
    input valid
  );

endinterface

// File: source/lane_sampler.sv
/*
 * First receive stage. Registers the lane pads, the frame strobe and the
 * lane mode so the assembler works on aligned beats one cycle later
 */

`timescale 1ns/10ps

module lane_sampler (
  input  logic sync_n_d,
  input  logic rst,
  input  logic da,
  input  logic db,
  input  logic frame_start,
  input  logic two_lane,
  lane_if.src  lanes
);

  // ********************
  // Control registers
  // ********************

  // The strobe and the mode are control state and start out cleared
  always_ff @(posedge sync_n_d) begin
    if (rst) begin
      lanes.first    <= 1'b0;
      lanes.two_lane <= 1'b0;
      lanes.valid    <= 1'b0;
    end else begin
      lanes.first    <= frame_start;
      lanes.two_lane <= two_lane;
      // Every cycle carries a beat once out of reset
      lanes.valid    <= 1'b1;
    end
  end

  // ********************
  // Lane bits
  // ********************

  // The data bits are plain payload and follow the pads each cycle
  always_ff @(posedge sync_n_d) begin
    lanes.da <= da;
    lanes.db <= db;
  end

  // The converter marks only the MSB beat, so the strobe is a single pulse
  // and two in a row would point at a broken frame source
  a_strobe_single : assert property (
    @(posedge sync_n_d) disable iff (rst)
    frame_start |=> !frame_start
  ) else $error("frame_start held high for more than one cycle");

endmodule

// File: source/sample_formatter.sv
/*
 * Third receive stage. Turns an assembled word into a sign-extended 24-bit
 * two's complement sample and registers it with its valid and error strobes
 */

`timescale 1ns/10ps

module sample_formatter (
  input  logic                    sync_n_d,
  input  logic                    rst,
  word_if.dst                     words,
  output adc_rx_pkg::out_sample_t sample,
  output logic                    sample_valid,
  output logic                    frame_error
);

  adc_rx_pkg::sample_t twos_word;

  // ********************
  // Format conversion
  // ********************

  // Offset binary differs from two's complement only in the MSB
  assign twos_word = {words.data[adc_rx_pkg::SAMPLE_W-1] ^ words.offset_bin,
                      words.data[adc_rx_pkg::SAMPLE_W-2:0]};

  // ********************
  // Output register
  // ********************

  // The sample only moves on a valid word and holds its value otherwise
  always_ff @(posedge sync_n_d) begin
    if (rst) begin
      sample <= '0;
    end else if (words.valid) begin
      // Replicate bit 19 into the upper bits of the 24-bit sample
      sample <= {{(adc_rx_pkg::OUT_W - adc_rx_pkg::SAMPLE_W){twos_word[adc_rx_pkg::SAMPLE_W-1]}},
                 twos_word};
    end
  end

  // Errors go through the same register as the strobes so their order is kept
  always_ff @(posedge sync_n_d) begin
    if (rst) begin
      sample_valid <= 1'b0;
      frame_error  <= 1'b0;
    end else begin
      sample_valid <= words.valid;
      frame_error  <= words.frame_error;
    end
  end

  // Downstream logic may read sample at any time, so it only changes with a strobe
  a_sample_hold : assert property (
    @(posedge sync_n_d) disable iff (rst)
    !sample_valid |-> $stable(sample)
  ) else $error("sample changed without sample_valid");

endmodule

// File: source/word_assembler.sv
/*
 * Second receive stage. Shifts lane beats into 20-bit words, counts the
 * beats of each frame and flags frames that a new strobe cut short
 */

`timescale 1ns/10ps

module word_assembler (
  input  logic sync_n_d,
  input  logic rst,
  input  logic offset_bin,
  lane_if.dst  lanes,
  word_if.src  words
);

  adc_rx_pkg::sample_t                 shift_q;
  logic [adc_rx_pkg::BEAT_CNT_W-1:0] beat_cnt;
  logic [adc_rx_pkg::BEAT_CNT_W-1:0] beat_next;
  logic [adc_rx_pkg::BEAT_CNT_W-1:0] beat_limit;
  logic                              take_beat;
  logic                              word_done;
  logic                              cut_short;
  logic                              fmt_q;

  // ********************
  // Beat bookkeeping
  // ********************

  // Number of beats that make up one word in the current lane mode
  assign beat_limit = lanes.two_lane ? adc_rx_pkg::BEATS_2L : adc_rx_pkg::BEATS_1L;

  // A beat counts when it opens a frame or when a word is already underway
  // Beats seen while idle and without a strobe are ignored
  assign take_beat = lanes.valid && (lanes.first || (beat_cnt != '0));

  // A strobe restarts the count at one, any other beat adds to it
  assign beat_next = lanes.first ? 5'd1 : beat_cnt + 5'd1;

  always_ff @(posedge sync_n_d) begin
    if (rst) begin
      beat_cnt  <= '0;
      word_done <= 1'b0;
      cut_short <= 1'b0;
      fmt_q     <= 1'b0;
    end else begin
      word_done <= 1'b0;
      cut_short <= 1'b0;
      if (take_beat) begin
        // A strobe in the middle of a word means the previous frame was short
        cut_short <= lanes.first && (beat_cnt != '0);
        if (beat_next == beat_limit) begin
          // Word complete, go idle so a strobe on the next beat is clean
          beat_cnt  <= '0;
          word_done <= 1'b1;
        end else begin
          beat_cnt <= beat_next;
        end
        // The format select is taken with the MSB so it stays with its word
        if (lanes.first) begin
          fmt_q <= offset_bin;
        end
      end
    end
  end

  // ********************
  // Shift register
  // ********************

  // Bits enter at the bottom, so after a full frame the first beat sits at the MSB
  // Stale bits from a dropped word are pushed out by the next full frame
  always_ff @(posedge sync_n_d) begin
    if (take_beat) begin
      if (lanes.two_lane) begin
        shift_q <= {shift_q[adc_rx_pkg::SAMPLE_W-3:0], lanes.da, lanes.db};
      end else begin
        shift_q <= {shift_q[adc_rx_pkg::SAMPLE_W-2:0], lanes.da};
      end
    end
  end

  // ********************
  // Word output
  // ********************

  // One register stage after the last beat, which also frees shift_q for the next frame
  always_ff @(posedge sync_n_d) begin
    if (rst) begin
      words.valid       <= 1'b0;
      words.frame_error <= 1'b0;
      words.offset_bin  <= 1'b0;
    end else begin
      words.valid       <= word_done;
      words.frame_error <= cut_short;
      words.offset_bin  <= fmt_q;
    end
  end

  always_ff @(posedge sync_n_d) begin
    words.data <= shift_q;
  end

  // A dropped frame restarts the count at one, so it can never also finish a word
  a_valid_error_exclusive : assert property (
    @(posedge sync_n_d) disable iff (rst)
    !(words.valid && words.frame_error)
  ) else $error("word valid and frame_error pulsed together");

  // The count returns to zero on reaching the limit, so it stays below it
  // unless the lane mode moves while a frame is open
  a_beat_cnt_range : assert property (
    @(posedge sync_n_d) disable iff (rst)
    beat_cnt < beat_limit
  ) else $error("beat counter %0d beyond limit %0d", beat_cnt, beat_limit);

endmodule

// File: source/word_if.sv
/*
 * Assembled converter words passed from the assembler to the formatter.
 * valid and frame_error are single-cycle pulses and never coincide
 */

`timescale 1ns/10ps

interface word_if;

  logic                valid;
  adc_rx_pkg::sample_t data;
  // Pulses when a frame was cut short and its partial word dropped
  logic                frame_error;
  // Format select that belongs to the word on data
  logic                offset_bin;

  modport src (
    output valid,
    output data,
    output frame_error,
    output offset_bin
  );

  modport dst (
    input valid,
    input data,
    input frame_error,
    input offset_bin
  );

endinterface
